//--- logic/graph_types_pkg.sv
package graph_types_pkg;

	////////////////////////////////
	// Field widths
	////////////////////////////////

	localparam int GRAPH_WORD_BITS = 32;
	localparam int VERTEX_ID_BITS  = 16;
	localparam int DEGREE_BITS     = 16;
	// Unsigned fixed point, sums wrap modulo 2^32
	localparam int RANK_BITS       = 32;

	// Tag carried next to every incoming word
	localparam logic WORD_KIND_VERTEX = 1'b0;
	localparam logic WORD_KIND_EDGE   = 1'b1;

	////////////////////////////////
	// Word views
	////////////////////////////////

	typedef struct packed {
		logic [VERTEX_ID_BITS-1:0] vertex_id;
		logic [DEGREE_BITS-1:0]    edge_count;
	} vertex_view_t;

	typedef struct packed {
		logic [RANK_BITS-1:0] edge_value;
	} edge_view_t;

	// Same 32 bits, read by word_kind
	typedef union packed {
		vertex_view_t vertex_view;
		edge_view_t   edge_view;
	} graph_word_u;

endpackage

//--- logic/unit_config_pkg.sv
package unit_config_pkg;

	////////////////////////////////
	// Queue sizing
	////////////////////////////////

	localparam int VERTEX_QUEUE_DEPTH = 16;
	localparam int EDGE_QUEUE_DEPTH   = 16;

	////////////////////////////////
	// Statistics counters
	////////////////////////////////

	// Finished vertices
	localparam int VERTEX_COUNT_BITS = 16;
	// Edges consumed by the sum
	localparam int EDGE_COUNT_BITS   = 32;

endpackage

//--- logic/job_queue.sv
`timescale 1ns/1ps

module job_queue #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	input  logic             pop,
	output logic [WIDTH-1:0] pop_data,
	output logic             empty,
	output logic             full
);
	localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	// Wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Push into a full queue is dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head is visible before the pop
	assign pop_data = mem[rd_ptr];
	assign empty    = (count == '0);
	assign full     = (count == COUNT_BITS'(DEPTH));

endmodule

//--- logic/graph_word_decode.sv
`timescale 1ns/1ps

module graph_word_decode (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 enabled,
	input  logic                                 word_valid,
	input  logic                                 word_kind,
	input  graph_types_pkg::graph_word_u         word_data,
	input  logic                                 vertex_pop,
	input  logic                                 edge_pop,
	output logic                                 vertex_ready,
	output graph_types_pkg::graph_word_u         vertex_word,
	output logic                                 edge_ready,
	output logic [graph_types_pkg::RANK_BITS-1:0] edge_value,
	output logic                                 enabled_q,
	output logic                                 job_request
);
	import graph_types_pkg::*;
	import unit_config_pkg::*;

	logic        word_valid_q;
	logic        word_kind_q;
	graph_word_u word_data_q;
	logic        vertex_push;
	logic        edge_push;
	logic        vertex_empty;
	logic        vertex_full;
	logic        edge_empty;
	logic        edge_full;

	////////////////////////////////
	// Input register
	////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			word_valid_q <= 1'b0;
			enabled_q    <= 1'b0;
		end else begin
			word_valid_q <= word_valid;
			enabled_q    <= enabled;
		end
	end

	always_ff @(posedge clock) begin
		word_kind_q <= word_kind;
		word_data_q <= word_data;
	end

	// Steer by tag
	assign vertex_push = word_valid_q && (word_kind_q == WORD_KIND_VERTEX);
	assign edge_push   = word_valid_q && (word_kind_q == WORD_KIND_EDGE);

	////////////////////////////////
	// Queues
	////////////////////////////////

	job_queue #(
		.WIDTH(GRAPH_WORD_BITS),
		.DEPTH(VERTEX_QUEUE_DEPTH)
	) vertex_queue (
		.clock    (clock),
		.rstn     (rstn),
		.push     (vertex_push),
		.push_data(word_data_q),
		.pop      (vertex_pop),
		.pop_data (vertex_word),
		.empty    (vertex_empty),
		.full     (vertex_full)
	);

	// Only the edge value is kept
	job_queue #(
		.WIDTH(RANK_BITS),
		.DEPTH(EDGE_QUEUE_DEPTH)
	) edge_queue (
		.clock    (clock),
		.rstn     (rstn),
		.push     (edge_push),
		.push_data(word_data_q.edge_view.edge_value),
		.pop      (edge_pop),
		.pop_data (edge_value),
		.empty    (edge_empty),
		.full     (edge_full)
	);

	assign vertex_ready = !vertex_empty;
	assign edge_ready   = !edge_empty;

	// Ask for more vertex work once the queue drains
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_request <= 1'b0;
		end else begin
			job_request <= vertex_empty;
		end
	end

endmodule

//--- logic/rank_sum_engine.sv
`timescale 1ns/1ps

module rank_sum_engine (
	input  logic                                      clock,
	input  logic                                      rstn,
	input  logic                                      enabled_q,
	input  logic                                      vertex_ready,
	input  graph_types_pkg::graph_word_u              vertex_word,
	input  logic                                      edge_ready,
	input  logic [graph_types_pkg::RANK_BITS-1:0]      edge_value,
	output logic                                      vertex_pop,
	output logic                                      edge_pop,
	output logic                                      edge_taken,
	output logic                                      done,
	output logic [graph_types_pkg::VERTEX_ID_BITS-1:0] done_vertex_id,
	output logic [graph_types_pkg::RANK_BITS-1:0]      done_rank_sum
);
	import graph_types_pkg::*;

	// Low is idle, high is summing edges of the held vertex
	logic                      accumulating;
	logic [DEGREE_BITS-1:0]    remaining;
	logic [VERTEX_ID_BITS-1:0] vertex_id;
	logic [RANK_BITS-1:0]      rank_sum;
	logic                      last_edge_seen;

	assign last_edge_seen = (remaining == '0);

	////////////////////////////////
	// Pop and finish strobes
	////////////////////////////////

	// Next vertex only when idle
	assign vertex_pop = !accumulating && vertex_ready && enabled_q;

	// One edge per cycle while edges remain
	assign edge_pop   = accumulating && !last_edge_seen && edge_ready && enabled_q;
	assign edge_taken = edge_pop;

	// Zero-edge vertex finishes on its first accumulating cycle
	assign done = accumulating && last_edge_seen && enabled_q;

	////////////////////////////////
	// Control state
	////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			accumulating <= 1'b0;
			remaining    <= '0;
		end else begin
			if (vertex_pop) begin
				accumulating <= 1'b1;
				remaining    <= vertex_word.vertex_view.edge_count;
			end else if (edge_pop) begin
				remaining <= remaining - 1'b1;
			end else if (done) begin
				accumulating <= 1'b0;
			end
		end
	end

	// Vertex id and running sum
	always_ff @(posedge clock) begin
		if (vertex_pop) begin
			vertex_id <= vertex_word.vertex_view.vertex_id;
			rank_sum  <= '0;
		end else if (edge_pop) begin
			// wraps modulo 2^32
			rank_sum <= rank_sum + edge_value;
		end
	end

	assign done_vertex_id = vertex_id;
	assign done_rank_sum  = rank_sum;

endmodule

//--- logic/rank_write_out.sv
`timescale 1ns/1ps

module rank_write_out (
	input  logic                                          clock,
	input  logic                                          rstn,
	input  logic                                          enabled_q,
	input  logic                                          done,
	input  logic [graph_types_pkg::VERTEX_ID_BITS-1:0]     done_vertex_id,
	input  logic [graph_types_pkg::RANK_BITS-1:0]          done_rank_sum,
	input  logic                                          edge_taken,
	output logic                                          write_valid,
	output logic [graph_types_pkg::VERTEX_ID_BITS-1:0]     write_vertex_id,
	output logic [graph_types_pkg::RANK_BITS-1:0]          write_rank_sum,
	output logic [unit_config_pkg::VERTEX_COUNT_BITS-1:0] vertex_count,
	output logic [unit_config_pkg::EDGE_COUNT_BITS-1:0]   edge_count
);

	////////////////////////////////
	// Write pulse
	////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_valid <= 1'b0;
		end else begin
			write_valid <= done;
		end
	end

	always_ff @(posedge clock) begin
		if (done) begin
			write_vertex_id <= done_vertex_id;
			write_rank_sum  <= done_rank_sum;
		end
	end

	////////////////////////////////
	// Running totals
	////////////////////////////////

	// Both totals freeze while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_count <= '0;
			edge_count   <= '0;
		end else if (enabled_q) begin
			if (done) begin
				vertex_count <= vertex_count + 1'b1;
			end
			if (edge_taken) begin
				edge_count <= edge_count + 1'b1;
			end
		end
	end

endmodule

//--- logic/pagerank_unit.sv
`timescale 1ns/1ps

module pagerank_unit (
	input  logic                                          clock,
	input  logic                                          rstn,
	input  logic                                          enabled,
	input  logic                                          word_valid,
	input  logic                                          word_kind,
	input  graph_types_pkg::graph_word_u                  word_data,
	output logic                                          job_request,
	output logic                                          write_valid,
	output logic [graph_types_pkg::VERTEX_ID_BITS-1:0]     write_vertex_id,
	output logic [graph_types_pkg::RANK_BITS-1:0]          write_rank_sum,
	output logic [unit_config_pkg::VERTEX_COUNT_BITS-1:0] vertex_count,
	output logic [unit_config_pkg::EDGE_COUNT_BITS-1:0]   edge_count
);
	import graph_types_pkg::*;

	logic                      enabled_q;
	logic                      vertex_ready;
	graph_word_u               vertex_word;
	logic                      edge_ready;
	logic [RANK_BITS-1:0]      edge_value;
	logic                      vertex_pop;
	logic                      edge_pop;
	logic                      edge_taken;
	logic                      done;
	logic [VERTEX_ID_BITS-1:0] done_vertex_id;
	logic [RANK_BITS-1:0]      done_rank_sum;

	////////////////////////////////
	// Decode
	////////////////////////////////

	graph_word_decode graph_word_decode_inst (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.word_valid  (word_valid),
		.word_kind   (word_kind),
		.word_data   (word_data),
		.vertex_pop  (vertex_pop),
		.edge_pop    (edge_pop),
		.vertex_ready(vertex_ready),
		.vertex_word (vertex_word),
		.edge_ready  (edge_ready),
		.edge_value  (edge_value),
		.enabled_q   (enabled_q),
		.job_request (job_request)
	);

	////////////////////////////////
	// Execute
	////////////////////////////////

	rank_sum_engine rank_sum_engine_inst (
		.clock         (clock),
		.rstn          (rstn),
		.enabled_q     (enabled_q),
		.vertex_ready  (vertex_ready),
		.vertex_word   (vertex_word),
		.edge_ready    (edge_ready),
		.edge_value    (edge_value),
		.vertex_pop    (vertex_pop),
		.edge_pop      (edge_pop),
		.edge_taken    (edge_taken),
		.done          (done),
		.done_vertex_id(done_vertex_id),
		.done_rank_sum (done_rank_sum)
	);

	////////////////////////////////
	// Result
	////////////////////////////////

	rank_write_out rank_write_out_inst (
		.clock          (clock),
		.rstn           (rstn),
		.enabled_q      (enabled_q),
		.done           (done),
		.done_vertex_id (done_vertex_id),
		.done_rank_sum  (done_rank_sum),
		.edge_taken     (edge_taken),
		.write_valid    (write_valid),
		.write_vertex_id(write_vertex_id),
		.write_rank_sum (write_rank_sum),
		.vertex_count   (vertex_count),
		.edge_count     (edge_count)
	);

endmodule

//--- bench/pagerank_unit_checker.sv
`timescale 1ns/1ps

module pagerank_unit_checker (
	input logic clock,
	input logic rstn,
	input logic vertex_pop,
	input logic vertex_ready,
	input logic edge_pop,
	input logic edge_ready,
	input logic vertex_push,
	input logic vertex_full,
	input logic edge_push,
	input logic edge_full,
	input logic done
);

	// Pops only from a queue that holds data
	vertex_pop_ready: assert property (@(posedge clock) disable iff (!rstn)
		vertex_pop |-> vertex_ready)
		else $error("vertex pop while the vertex queue is empty");
	edge_pop_ready: assert property (@(posedge clock) disable iff (!rstn)
		edge_pop |-> edge_ready)
		else $error("edge pop while the edge queue is empty");

	// No input back-pressure, so a full queue would drop the word
	vertex_push_room: assert property (@(posedge clock) disable iff (!rstn)
		vertex_push |-> !vertex_full)
		else $error("vertex word pushed into a full queue");
	edge_push_room: assert property (@(posedge clock) disable iff (!rstn)
		edge_push |-> !edge_full)
		else $error("edge word pushed into a full queue");

	// One strobe per finished vertex
	done_single: assert property (@(posedge clock) disable iff (!rstn)
		done |=> !done)
		else $error("done high on two cycles in a row");

endmodule

bind pagerank_unit pagerank_unit_checker pagerank_unit_checker_inst (
	.clock       (clock),
	.rstn        (rstn),
	.vertex_pop  (vertex_pop),
	.vertex_ready(vertex_ready),
	.edge_pop    (edge_pop),
	.edge_ready  (edge_ready),
	.vertex_push (graph_word_decode_inst.vertex_push),
	.vertex_full (graph_word_decode_inst.vertex_full),
	.edge_push   (graph_word_decode_inst.edge_push),
	.edge_full   (graph_word_decode_inst.edge_full),
	.done        (done)
);

//--- bench/pagerank_unit_tb.sv
`timescale 1ns/1ps

module pagerank_unit_tb;
	import graph_types_pkg::*;
	import unit_config_pkg::*;

	// Words sent over all tests, sets the watchdog
	localparam int TOTAL_WORDS   = 31;
	localparam int COLLECT_LIMIT = 100;

	logic                         clock;
	logic                         rstn;
	logic                         enabled;
	logic                         word_valid;
	logic                         word_kind;
	graph_word_u                  word_data;
	logic                         job_request;
	logic                         write_valid;
	logic [VERTEX_ID_BITS-1:0]    write_vertex_id;
	logic [RANK_BITS-1:0]         write_rank_sum;
	logic [VERTEX_COUNT_BITS-1:0] vertex_count;
	logic [EDGE_COUNT_BITS-1:0]   edge_count;

	integer                    seed;
	int                        mismatch_errors;
	int                        other_errors;
	int                        tot_vertices;
	int                        tot_edges;
	logic [VERTEX_ID_BITS-1:0] exp_id[$];
	logic [RANK_BITS-1:0]      exp_sum[$];
	logic [VERTEX_ID_BITS-1:0] got_id[$];
	logic [RANK_BITS-1:0]      got_sum[$];

	pagerank_unit pagerank_unit_inst (
		.clock          (clock),
		.rstn           (rstn),
		.enabled        (enabled),
		.word_valid     (word_valid),
		.word_kind      (word_kind),
		.word_data      (word_data),
		.job_request    (job_request),
		.write_valid    (write_valid),
		.write_vertex_id(write_vertex_id),
		.write_rank_sum (write_rank_sum),
		.vertex_count   (vertex_count),
		.edge_count     (edge_count)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Capture write pulses where outputs are stable
	always @(negedge clock) begin
		if (write_valid === 1'b1) begin
			got_id.push_back(write_vertex_id);
			got_sum.push_back(write_rank_sum);
		end
	end

	initial begin
		repeat (TOTAL_WORDS * 10 + 200) @(posedge clock);
		$display("Timeout: the tests did not finish in %0d cycles", TOTAL_WORDS * 10 + 200);
		$display("Testbench failed");
		$finish;
	end

	////////////////////////////////
	// Stimulus and reference model
	////////////////////////////////

	task automatic check_value(input string name, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch %s %s: expected %0h, actual %0h", name, field, expected, actual);
			mismatch_errors++;
		end
	endtask

	task automatic send_word(input logic kind, input graph_word_u data);
		@(negedge clock);
		word_valid = 1'b1;
		word_kind  = kind;
		word_data  = data;
	endtask

	task automatic stop_input();
		@(negedge clock);
		word_valid = 1'b0;
	endtask

	task automatic send_vertex(input logic [VERTEX_ID_BITS-1:0] id,
			input logic [DEGREE_BITS-1:0] n);
		graph_word_u w;
		w.vertex_view.vertex_id  = id;
		w.vertex_view.edge_count = n;
		send_word(WORD_KIND_VERTEX, w);
	endtask

	// Sum of the sent values in order, modulo 2^32
	task automatic send_edges(input int n, output logic [RANK_BITS-1:0] sum);
		graph_word_u w;
		int i;
		sum = '0;
		for (i = 0; i < n; i++) begin
			w.edge_view.edge_value = $random(seed);
			sum = sum + w.edge_view.edge_value;
			send_word(WORD_KIND_EDGE, w);
		end
		tot_edges += n;
	endtask

	task automatic expect_result(input logic [VERTEX_ID_BITS-1:0] id,
			input logic [RANK_BITS-1:0] sum);
		exp_id.push_back(id);
		exp_sum.push_back(sum);
		tot_vertices++;
	endtask

	task automatic collect_writes(input string name);
		int waited;
		waited = 0;
		while (got_id.size() < exp_id.size() && waited < COLLECT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		assert (got_id.size() >= exp_id.size()) else begin
			$display("%s: only %0d of %0d write pulses arrived", name, got_id.size(),
				exp_id.size());
			other_errors++;
		end
		while (exp_id.size() > 0 && got_id.size() > 0) begin
			check_value(name, "vertex id", exp_id.pop_front(), got_id.pop_front());
			check_value(name, "rank sum", exp_sum.pop_front(), got_sum.pop_front());
		end
		exp_id.delete();
		exp_sum.delete();
		got_id.delete();
		got_sum.delete();
	endtask

	task automatic check_totals(input string name);
		check_value(name, "vertex_count", tot_vertices, vertex_count);
		check_value(name, "edge_count", tot_edges, edge_count);
		check_value(name, "job_request", 1, job_request);
	endtask

	////////////////////////////////
	// Directed tests
	////////////////////////////////

	task automatic test_reset_state();
		check_value("reset_state", "write_valid", 0, write_valid);
		check_value("reset_state", "vertex_count", 0, vertex_count);
		check_value("reset_state", "edge_count", 0, edge_count);
		check_value("reset_state", "job_request", 0, job_request);
		// Empty vertex queue raises the request one cycle later
		@(negedge clock);
		check_value("reset_state", "job_request", 1, job_request);
	endtask

	task automatic test_three_edges();
		logic [RANK_BITS-1:0] sum;
		send_vertex(16'h0011, 16'd3);
		send_edges(3, sum);
		expect_result(16'h0011, sum);
		stop_input();
		collect_writes("three_edges");
		check_totals("three_edges");
	endtask

	task automatic test_zero_edges();
		send_vertex(16'h0022, 16'd0);
		expect_result(16'h0022, '0);
		stop_input();
		collect_writes("zero_edges");
		check_totals("zero_edges");
	endtask

	task automatic test_queued_vertices();
		logic [DEGREE_BITS-1:0] counts [4];
		logic [RANK_BITS-1:0]   sum;
		int                     i;
		counts = '{16'd2, 16'd0, 16'd3, 16'd1};
		for (i = 0; i < 4; i++) begin
			send_vertex(VERTEX_ID_BITS'(16'h0100 + i), counts[i]);
		end
		for (i = 0; i < 4; i++) begin
			send_edges(counts[i], sum);
			expect_result(VERTEX_ID_BITS'(16'h0100 + i), sum);
		end
		stop_input();
		collect_writes("queued_vertices");
		check_totals("queued_vertices");
	endtask

	task automatic test_edges_first();
		logic [RANK_BITS-1:0] sum;
		send_edges(3, sum);
		send_vertex(16'h0044, 16'd3);
		expect_result(16'h0044, sum);
		stop_input();
		collect_writes("edges_first");
		check_totals("edges_first");
	endtask

	task automatic test_disabled_hold();
		logic [RANK_BITS-1:0] sum;
		@(negedge clock);
		enabled = 1'b0;
		send_vertex(16'h0055, 16'd2);
		send_edges(2, sum);
		expect_result(16'h0055, sum);
		send_vertex(16'h0056, 16'd3);
		send_edges(3, sum);
		expect_result(16'h0056, sum);
		stop_input();
		repeat (20) @(negedge clock);
		assert (got_id.size() == 0) else begin
			$display("disabled_hold: a write pulse appeared while the unit was disabled");
			other_errors++;
		end
		check_value("disabled_hold", "vertex_count", tot_vertices - 2, vertex_count);
		check_value("disabled_hold", "edge_count", tot_edges - 5, edge_count);
		// Vertex words still waiting in the queue
		check_value("disabled_hold", "job_request", 0, job_request);
		enabled = 1'b1;
		collect_writes("disabled_hold");
		check_totals("disabled_hold");
	endtask

	task automatic test_running_totals();
		logic [RANK_BITS-1:0] sum;
		send_vertex(16'h0077, 16'd1);
		send_edges(1, sum);
		expect_result(16'h0077, sum);
		send_vertex(16'h0078, 16'd2);
		send_edges(2, sum);
		expect_result(16'h0078, sum);
		stop_input();
		collect_writes("running_totals");
		check_totals("running_totals");
	endtask

	initial begin
		seed            = 32'h60a1;
		mismatch_errors = 0;
		other_errors    = 0;
		tot_vertices    = 0;
		tot_edges       = 0;
		rstn            = 1'b0;
		enabled         = 1'b1;
		word_valid      = 1'b0;
		word_kind       = WORD_KIND_VERTEX;
		word_data       = '0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		test_reset_state();
		test_three_edges();
		test_zero_edges();
		test_queued_vertices();
		test_edges_first();
		test_disabled_hold();
		test_running_totals();

		$display("Summary: %0d mismatches, %0d other errors", mismatch_errors, other_errors);
		if (mismatch_errors + other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- all.f
logic/graph_types_pkg.sv
logic/unit_config_pkg.sv
logic/job_queue.sv
logic/graph_word_decode.sv
logic/rank_sum_engine.sv
logic/rank_write_out.sv
logic/pagerank_unit.sv
bench/pagerank_unit_checker.sv
bench/pagerank_unit_tb.sv
